// File: hdl/wr_guard_pkg.sv
// Write guard sizes, index and counter types, state and fault enums, table records
package wr_guard_pkg;

  localparam int unsigned MaxWrTxns  = 4;
  localparam int unsigned HtCapacity = 4;
  localparam int unsigned IdWidth    = 4;
  localparam int unsigned CntWidth   = 8;
  localparam int unsigned LdIdxWidth = $clog2(MaxWrTxns);
  localparam int unsigned HtIdxWidth = $clog2(HtCapacity);
  // W-order FIFO depth equals MaxWrTxns, a power of two so pointers wrap naturally
  localparam int unsigned PtrWidth   = $clog2(MaxWrTxns);
  localparam int unsigned MaxCnt     = (2 ** CntWidth) - 1;

  typedef logic [IdWidth-1:0]    id_t;
  typedef logic [7:0]            len_t;
  typedef logic [CntWidth-1:0]   cnt_t;
  typedef logic [LdIdxWidth-1:0] ld_idx_t;
  typedef logic [HtIdxWidth-1:0] ht_idx_t;
  typedef logic [PtrWidth-1:0]   ptr_t;

  typedef enum logic [1:0] {
    WRITE_IDLE     = 2'd0,
    WRITE_ADDRESS  = 2'd1,
    WRITE_DATA     = 2'd2,
    WRITE_RESPONSE = 2'd3
  } write_state_e;

  typedef enum logic [2:0] {
    FAULT_NONE       = 3'd0,
    FAULT_AW_W       = 3'd1,
    FAULT_W_DATA     = 3'd2,
    FAULT_B_WAIT     = 3'd3,
    FAULT_UNWANTED_B = 3'd4
  } fault_e;

  // One record per outstanding write, chained per ID through next
  typedef struct packed {
    id_t          id;
    len_t         len;
    write_state_e state;
    cnt_t         w1_budget;
    cnt_t         w3_budget;
    ld_idx_t      next;
    logic         free;
  } linked_data_t;

  typedef struct packed {
    id_t     id;
    ld_idx_t head;
    ld_idx_t tail;
    logic    free;
  } head_tail_t;

endpackage

// File: hdl/wr_mon_if.sv
// Observed AW, W and B channel signals with driver and monitor views
`timescale 1ns/100ps

interface wr_mon_if
  import wr_guard_pkg::*;
();

  logic aw_valid;
  logic aw_ready;
  id_t  aw_id;
  len_t aw_len;
  logic w_valid;
  logic w_ready;
  logic w_last;
  logic b_valid;
  logic b_ready;
  id_t  b_id;

  modport bus (
    output aw_valid, aw_ready, aw_id, aw_len, w_valid, w_ready, w_last, b_valid, b_ready, b_id
  );

  modport monitor (
    input aw_valid, aw_ready, aw_id, aw_len, w_valid, w_ready, w_last, b_valid, b_ready, b_id
  );

endinterface

// File: hdl/txn_lookup.sv
// Free slot search and AW/B ID matching over the head/tail and record tables
`timescale 1ns/100ps

module txn_lookup
  import wr_guard_pkg::*;
(
  wr_mon_if.monitor                    mon,
  input  head_tail_t [HtCapacity-1:0]  head_tail_i,
  input  linked_data_t [MaxWrTxns-1:0] linked_data_i,
  output ht_idx_t                      ht_free_idx_o,
  output ld_idx_t                      ld_free_idx_o,
  output logic                         ld_free_valid_o,
  output logic                         no_id_match_o,
  output ht_idx_t                      match_idx_o,
  output logic                         id_exists_o,
  output ht_idx_t                      rsp_idx_o
);

  logic [HtCapacity-1:0] aw_hit;
  logic [HtCapacity-1:0] b_hit;

  // Scans run downwards so the lowest index is the one left standing
  always_comb begin : proc_ht_search
    ht_free_idx_o = '0;
    no_id_match_o = 1'b1;
    match_idx_o   = '0;
    id_exists_o   = 1'b0;
    rsp_idx_o     = '0;
    for (int i = HtCapacity - 1; i >= 0; i--) begin
      if (head_tail_i[i].free) begin
        ht_free_idx_o = ht_idx_t'(i);
      end else begin
        if (head_tail_i[i].id == mon.aw_id) begin
          no_id_match_o = 1'b0;
          match_idx_o   = ht_idx_t'(i);
        end
        if (head_tail_i[i].id == mon.b_id) begin
          id_exists_o = 1'b1;
          rsp_idx_o   = ht_idx_t'(i);
        end
      end
    end
  end

  always_comb begin : proc_ld_search
    ld_free_idx_o   = '0;
    ld_free_valid_o = 1'b0;
    for (int i = MaxWrTxns - 1; i >= 0; i--) begin
      if (linked_data_i[i].free) begin
        ld_free_idx_o   = ld_idx_t'(i);
        ld_free_valid_o = 1'b1;
      end
    end
  end

  // Enqueue appends to an existing ID, so a looked-up ID sits in one live entry at most
  always_comb begin : proc_unique_id_check
    for (int i = 0; i < HtCapacity; i++) begin
      aw_hit[i] = !head_tail_i[i].free && (head_tail_i[i].id == mon.aw_id);
      b_hit[i]  = !head_tail_i[i].free && (head_tail_i[i].id == mon.b_id);
    end
    if (mon.aw_valid && mon.aw_ready) begin
      assert final ($onehot0(aw_hit)) else $error("AW ID matches several head/tail entries");
    end
    if (mon.b_valid && mon.b_ready) begin
      assert final ($onehot0(b_hit)) else $error("B ID matches several head/tail entries");
    end
  end

endmodule

// File: hdl/txn_counters.sv
// Per-record phase cycle counters, restarted on every state change
`timescale 1ns/100ps

module txn_counters
  import wr_guard_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         clear_i,
  input  write_state_e [MaxWrTxns-1:0] state_q_i,
  input  write_state_e [MaxWrTxns-1:0] state_d_i,
  output cnt_t [MaxWrTxns-1:0]         count_o
);

  cnt_t [MaxWrTxns-1:0] count_q;

  always_ff @(posedge clk_i) begin : proc_count
    if (reset_i || clear_i) begin
      count_q <= '0;
    end else begin
      for (int i = 0; i < MaxWrTxns; i++) begin
        // Zero in the first cycle of each phase, held at zero while idle
        if ((state_d_i[i] != state_q_i[i]) || (state_d_i[i] == WRITE_IDLE)) begin
          count_q[i] <= '0;
        end else if (count_q[i] != cnt_t'(MaxCnt)) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  assign count_o = count_q;

  // A freed record must start its next phase from zero
  for (genvar i = 0; i < MaxWrTxns; i++) begin : gen_idle_check
    assert property (@(posedge clk_i) disable iff (reset_i)
      (state_q_i[i] == WRITE_IDLE) |-> (count_o[i] == '0))
      else $error("record %0d counts while idle", i);
  end

endmodule

// File: hdl/wr_txn_manager.sv
// Enqueue, phase transitions, budget checks, dequeue and fault clearing of tracked writes
`timescale 1ns/100ps

module wr_txn_manager
  import wr_guard_pkg::*;
(
  wr_mon_if.monitor                     mon,
  input  cnt_t                          budget_b_wait_i,
  input  head_tail_t [HtCapacity-1:0]   head_tail_q_i,
  input  linked_data_t [MaxWrTxns-1:0]  linked_data_q_i,
  input  cnt_t [MaxWrTxns-1:0]          count_i,
  input  ht_idx_t                       ht_free_idx_i,
  input  ld_idx_t                       ld_free_idx_i,
  input  logic                          ld_free_valid_i,
  input  logic                          no_id_match_i,
  input  ht_idx_t                       match_idx_i,
  input  logic                          id_exists_i,
  input  ht_idx_t                       rsp_idx_i,
  input  ld_idx_t [MaxWrTxns-1:0]       fifo_q_i,
  input  ptr_t                          wr_ptr_q_i,
  input  ptr_t                          rd_ptr_q_i,
  input  logic                          full_q_i,
  input  logic                          empty_q_i,
  input  logic                          irq_q_i,
  output head_tail_t [HtCapacity-1:0]   head_tail_d_o,
  output linked_data_t [MaxWrTxns-1:0]  linked_data_d_o,
  output write_state_e [MaxWrTxns-1:0]  state_d_o,
  output ld_idx_t [MaxWrTxns-1:0]       fifo_d_o,
  output ptr_t                          wr_ptr_d_o,
  output ptr_t                          rd_ptr_d_o,
  output logic                          full_d_o,
  output logic                          empty_d_o,
  output fault_e                        fault_o,
  output id_t                           fault_id_o,
  output cnt_t                          lat_aw_w_d_o,
  output cnt_t                          lat_w_data_d_o,
  output cnt_t                          lat_b_wait_d_o,
  output logic                          lat_aw_w_valid_o,
  output logic                          lat_w_data_valid_o,
  output logic                          lat_b_wait_valid_o
);

  logic    aw_hs;
  logic    w_hs;
  logic    b_hs;
  ld_idx_t act_idx;
  ld_idx_t rsp_head;
  cnt_t    w1_budget;
  cnt_t    w3_budget;

  function automatic cnt_t sat_cnt(int unsigned value);
    return (value > MaxCnt) ? cnt_t'(MaxCnt) : cnt_t'(value);
  endfunction

  // Cycles between the two handshakes of a phase
  function automatic cnt_t lat_of(cnt_t count);
    return (count == cnt_t'(MaxCnt)) ? count : cnt_t'(count + 1'b1);
  endfunction

  assign aw_hs    = mon.aw_valid && mon.aw_ready;
  assign w_hs     = mon.w_valid && mon.w_ready;
  assign b_hs     = mon.b_valid && mon.b_ready;
  assign act_idx  = fifo_q_i[rd_ptr_q_i];
  assign rsp_head = head_tail_q_i[rsp_idx_i].head;

  always_comb begin : proc_budgets
    int unsigned accum;
    accum = 2;
    // Every burst still queued for W goes out before the new one
    for (int i = 0; i < MaxWrTxns; i++) begin
      if (!linked_data_q_i[i].free && ((linked_data_q_i[i].state == WRITE_ADDRESS) ||
                                       (linked_data_q_i[i].state == WRITE_DATA))) begin
        accum += int'(linked_data_q_i[i].len) + 1;
      end
    end
    w1_budget = sat_cnt(accum);
    w3_budget = sat_cnt(int'(mon.aw_len) + 3);
  end

  always_comb begin : proc_manager
    logic push;
    logic pop;
    push               = 1'b0;
    pop                = 1'b0;
    head_tail_d_o      = head_tail_q_i;
    linked_data_d_o    = linked_data_q_i;
    fifo_d_o           = fifo_q_i;
    wr_ptr_d_o         = wr_ptr_q_i;
    rd_ptr_d_o         = rd_ptr_q_i;
    full_d_o           = full_q_i;
    empty_d_o          = empty_q_i;
    fault_o            = FAULT_NONE;
    fault_id_o         = '0;
    lat_aw_w_d_o       = '0;
    lat_w_data_d_o     = '0;
    lat_b_wait_d_o     = '0;
    lat_aw_w_valid_o   = 1'b0;
    lat_w_data_valid_o = 1'b0;
    lat_b_wait_valid_o = 1'b0;

    // Lowest record index wins when several budgets run out together
    for (int i = 0; i < MaxWrTxns; i++) begin
      if (!linked_data_q_i[i].free && (fault_o == FAULT_NONE)) begin
        case (linked_data_q_i[i].state)
          WRITE_ADDRESS:  if (count_i[i] > linked_data_q_i[i].w1_budget) fault_o = FAULT_AW_W;
          WRITE_DATA:     if (count_i[i] > linked_data_q_i[i].w3_budget) fault_o = FAULT_W_DATA;
          WRITE_RESPONSE: if (count_i[i] > budget_b_wait_i) fault_o = FAULT_B_WAIT;
          default:        fault_o = FAULT_NONE;
        endcase
        if (fault_o != FAULT_NONE) begin
          fault_id_o = linked_data_q_i[i].id;
        end
      end
    end
    if (b_hs && !id_exists_i && (fault_o == FAULT_NONE)) begin
      fault_o    = FAULT_UNWANTED_B;
      fault_id_o = mon.b_id;
    end

    if (fault_o != FAULT_NONE) begin
      // Drop every tracked write
      for (int i = 0; i < MaxWrTxns; i++) begin
        linked_data_d_o[i]      = '0;
        linked_data_d_o[i].free = 1'b1;
      end
      for (int i = 0; i < HtCapacity; i++) begin
        head_tail_d_o[i]      = '0;
        head_tail_d_o[i].free = 1'b1;
      end
      wr_ptr_d_o = '0;
      rd_ptr_d_o = '0;
      full_d_o   = 1'b0;
      empty_d_o  = 1'b1;
    end else begin
      // W beats belong to the record at the FIFO read pointer
      if (w_hs && !empty_q_i) begin
        if (linked_data_q_i[act_idx].state == WRITE_ADDRESS) begin
          lat_aw_w_d_o     = lat_of(count_i[act_idx]);
          lat_aw_w_valid_o = 1'b1;
          linked_data_d_o[act_idx].state = WRITE_DATA;
        end
        if (mon.w_last) begin
          // Single-beat burst has no data phase of its own
          lat_w_data_d_o = (linked_data_q_i[act_idx].state == WRITE_DATA) ?
                           lat_of(count_i[act_idx]) : '0;
          lat_w_data_valid_o = 1'b1;
          linked_data_d_o[act_idx].state = WRITE_RESPONSE;
          pop        = 1'b1;
          rd_ptr_d_o = ptr_t'(rd_ptr_q_i + 1'b1);
        end
      end

      // Matched B retires the oldest record of its ID
      if (b_hs && id_exists_i) begin
        lat_b_wait_d_o     = lat_of(count_i[rsp_head]);
        lat_b_wait_valid_o = 1'b1;
        linked_data_d_o[rsp_head]      = '0;
        linked_data_d_o[rsp_head].free = 1'b1;
        if (rsp_head == head_tail_q_i[rsp_idx_i].tail) begin
          head_tail_d_o[rsp_idx_i]      = '0;
          head_tail_d_o[rsp_idx_i].free = 1'b1;
        end else begin
          head_tail_d_o[rsp_idx_i].head = linked_data_q_i[rsp_head].next;
        end
      end

      if (aw_hs && ld_free_valid_i && !irq_q_i && !full_q_i) begin
        push = 1'b1;
        linked_data_d_o[ld_free_idx_i] = '{
          id:        mon.aw_id,
          len:       mon.aw_len,
          state:     WRITE_ADDRESS,
          w1_budget: w1_budget,
          w3_budget: w3_budget,
          next:      '0,
          free:      1'b0
        };
        // New chain when the ID is unknown or its last record leaves this cycle
        if (no_id_match_i) begin
          head_tail_d_o[ht_free_idx_i] = '{mon.aw_id, ld_free_idx_i, ld_free_idx_i, 1'b0};
        end else if (head_tail_d_o[match_idx_i].free) begin
          head_tail_d_o[match_idx_i] = '{mon.aw_id, ld_free_idx_i, ld_free_idx_i, 1'b0};
        end else begin
          linked_data_d_o[head_tail_q_i[match_idx_i].tail].next = ld_free_idx_i;
          head_tail_d_o[match_idx_i].tail = ld_free_idx_i;
        end
        fifo_d_o[wr_ptr_q_i] = ld_free_idx_i;
        wr_ptr_d_o = ptr_t'(wr_ptr_q_i + 1'b1);
      end

      if (push != pop) begin
        full_d_o  = push && (wr_ptr_d_o == rd_ptr_d_o);
        empty_d_o = pop && (wr_ptr_d_o == rd_ptr_d_o);
      end
    end

    for (int i = 0; i < MaxWrTxns; i++) begin
      state_d_o[i] = linked_data_d_o[i].state;
    end
  end

  // Pointer equality must be resolved by exactly one of the two flags
  always_comb begin : proc_fifo_flag_check
    assert final (!(full_q_i && empty_q_i)) else $error("W-order FIFO both full and empty");
  end

endmodule

// File: hdl/wr_guard_top.sv
// Write guard top with table and FIFO registers, sticky fault and latency outputs
`timescale 1ns/100ps

module wr_guard_top
  import wr_guard_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   aw_valid_i,
  input  logic   aw_ready_i,
  input  id_t    aw_id_i,
  input  len_t   aw_len_i,
  input  logic   w_valid_i,
  input  logic   w_ready_i,
  input  logic   w_last_i,
  input  logic   b_valid_i,
  input  logic   b_ready_i,
  input  id_t    b_id_i,
  input  cnt_t   budget_b_wait_i,
  output logic   irq_o,
  output fault_e cause_o,
  output id_t    fault_id_o,
  output cnt_t   lat_aw_w_o,
  output cnt_t   lat_w_data_o,
  output cnt_t   lat_b_wait_o
);

  head_tail_t [HtCapacity-1:0]  head_tail_q, head_tail_d;
  linked_data_t [MaxWrTxns-1:0] linked_data_q, linked_data_d;
  write_state_e [MaxWrTxns-1:0] state_q, state_d;
  ld_idx_t [MaxWrTxns-1:0]      fifo_q, fifo_d;
  cnt_t [MaxWrTxns-1:0]         count;
  ptr_t    wr_ptr_q, wr_ptr_d, rd_ptr_q, rd_ptr_d;
  logic    full_q, full_d, empty_q, empty_d;
  ht_idx_t ht_free_idx, match_idx, rsp_idx;
  ld_idx_t ld_free_idx;
  logic    ld_free_valid, no_id_match, id_exists;
  fault_e  fault;
  id_t     fault_id;
  cnt_t    lat_aw_w_d, lat_w_data_d, lat_b_wait_d;
  logic    lat_aw_w_valid, lat_w_data_valid, lat_b_wait_valid;

  wr_mon_if mon ();

  assign mon.aw_valid = aw_valid_i;
  assign mon.aw_ready = aw_ready_i;
  assign mon.aw_id    = aw_id_i;
  assign mon.aw_len   = aw_len_i;
  assign mon.w_valid  = w_valid_i;
  assign mon.w_ready  = w_ready_i;
  assign mon.w_last   = w_last_i;
  assign mon.b_valid  = b_valid_i;
  assign mon.b_ready  = b_ready_i;
  assign mon.b_id     = b_id_i;

  always_comb begin : proc_state_q
    for (int i = 0; i < MaxWrTxns; i++) begin
      state_q[i] = linked_data_q[i].state;
    end
  end

  txn_lookup u_lookup (
    .mon             (mon),
    .head_tail_i     (head_tail_q),
    .linked_data_i   (linked_data_q),
    .ht_free_idx_o   (ht_free_idx),
    .ld_free_idx_o   (ld_free_idx),
    .ld_free_valid_o (ld_free_valid),
    .no_id_match_o   (no_id_match),
    .match_idx_o     (match_idx),
    .id_exists_o     (id_exists),
    .rsp_idx_o       (rsp_idx)
  );

  txn_counters u_counters (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .clear_i   (fault != FAULT_NONE),
    .state_q_i (state_q),
    .state_d_i (state_d),
    .count_o   (count)
  );

  wr_txn_manager u_manager (
    .mon                (mon),
    .budget_b_wait_i    (budget_b_wait_i),
    .head_tail_q_i      (head_tail_q),
    .linked_data_q_i    (linked_data_q),
    .count_i            (count),
    .ht_free_idx_i      (ht_free_idx),
    .ld_free_idx_i      (ld_free_idx),
    .ld_free_valid_i    (ld_free_valid),
    .no_id_match_i      (no_id_match),
    .match_idx_i        (match_idx),
    .id_exists_i        (id_exists),
    .rsp_idx_i          (rsp_idx),
    .fifo_q_i           (fifo_q),
    .wr_ptr_q_i         (wr_ptr_q),
    .rd_ptr_q_i         (rd_ptr_q),
    .full_q_i           (full_q),
    .empty_q_i          (empty_q),
    .irq_q_i            (irq_o),
    .head_tail_d_o      (head_tail_d),
    .linked_data_d_o    (linked_data_d),
    .state_d_o          (state_d),
    .fifo_d_o           (fifo_d),
    .wr_ptr_d_o         (wr_ptr_d),
    .rd_ptr_d_o         (rd_ptr_d),
    .full_d_o           (full_d),
    .empty_d_o          (empty_d),
    .fault_o            (fault),
    .fault_id_o         (fault_id),
    .lat_aw_w_d_o       (lat_aw_w_d),
    .lat_w_data_d_o     (lat_w_data_d),
    .lat_b_wait_d_o     (lat_b_wait_d),
    .lat_aw_w_valid_o   (lat_aw_w_valid),
    .lat_w_data_valid_o (lat_w_data_valid),
    .lat_b_wait_valid_o (lat_b_wait_valid)
  );

  always_ff @(posedge clk_i) begin : proc_tables
    if (reset_i) begin
      for (int i = 0; i < MaxWrTxns; i++) begin
        linked_data_q[i]      <= '0;
        linked_data_q[i].free <= 1'b1;
      end
      for (int i = 0; i < HtCapacity; i++) begin
        head_tail_q[i]      <= '0;
        head_tail_q[i].free <= 1'b1;
      end
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      linked_data_q <= linked_data_d;
      head_tail_q   <= head_tail_d;
      wr_ptr_q      <= wr_ptr_d;
      rd_ptr_q      <= rd_ptr_d;
      full_q        <= full_d;
      empty_q       <= empty_d;
    end
  end

  always_ff @(posedge clk_i) begin : proc_fifo
    fifo_q <= fifo_d;
  end

  always_ff @(posedge clk_i) begin : proc_outputs
    if (reset_i) begin
      irq_o        <= 1'b0;
      cause_o      <= FAULT_NONE;
      fault_id_o   <= '0;
      lat_aw_w_o   <= '0;
      lat_w_data_o <= '0;
      lat_b_wait_o <= '0;
    end else begin
      // Only the first fault is kept until reset
      if ((fault != FAULT_NONE) && !irq_o) begin
        irq_o      <= 1'b1;
        cause_o    <= fault;
        fault_id_o <= fault_id;
      end
      if (lat_aw_w_valid) begin
        lat_aw_w_o <= lat_aw_w_d;
      end
      if (lat_w_data_valid) begin
        lat_w_data_o <= lat_w_data_d;
      end
      if (lat_b_wait_valid) begin
        lat_b_wait_o <= lat_b_wait_d;
      end
    end
  end

endmodule

// File: dv/wr_guard_tb.sv
// Testbench for the write guard with scenario table, budget model, checks and summary
`timescale 1ns/100ps

module wr_guard_tb
  import wr_guard_pkg::*;
();

  localparam int NumRows    = 10;
  localparam int CycleLimit = 40 * NumRows + 100;

  // One scenario of one or two writes, B IDs of the second write follow its AW ID
  typedef struct packed {
    logic       rst;
    logic [1:0] n;
    id_t        id0;
    id_t        id1;
    len_t       len;
    logic [7:0] gap;
    logic [7:0] stall;
    logic [7:0] bdly;
    cnt_t       bwait;
    id_t        bid;
    logic       fault;
  } row_t;

  logic   clk;
  logic   reset;
  logic   aw_valid;
  logic   aw_ready;
  id_t    aw_id;
  len_t   aw_len;
  logic   w_valid;
  logic   w_ready;
  logic   w_last;
  logic   b_valid;
  logic   b_ready;
  id_t    b_id;
  cnt_t   budget_b_wait;
  logic   irq;
  fault_e cause;
  id_t    fault_id;
  cnt_t   lat_aw_w;
  cnt_t   lat_w_data;
  cnt_t   lat_b_wait;

  row_t        rows [NumRows];
  row_t        cur;
  int          a_cyc [2];
  int          f_cyc [2];
  int          l_cyc [2];
  int          b_cyc [2];
  int          w1 [2];
  id_t         aw_ids [2];
  id_t         b_ids [2];
  int          last_cyc;
  int unsigned lcg_state;
  logic        exp_irq;
  fault_e      exp_cause;
  id_t         exp_id;
  int          row_errors;
  int          tests_failed;
  int          cycles;

  wr_guard_top u_dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .aw_valid_i      (aw_valid),
    .aw_ready_i      (aw_ready),
    .aw_id_i         (aw_id),
    .aw_len_i        (aw_len),
    .w_valid_i       (w_valid),
    .w_ready_i       (w_ready),
    .w_last_i        (w_last),
    .b_valid_i       (b_valid),
    .b_ready_i       (b_ready),
    .b_id_i          (b_id),
    .budget_b_wait_i (budget_b_wait),
    .irq_o           (irq),
    .cause_o         (cause),
    .fault_id_o      (fault_id),
    .lat_aw_w_o      (lat_aw_w),
    .lat_w_data_o    (lat_w_data),
    .lat_b_wait_o    (lat_b_wait)
  );

  initial begin : proc_clock
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : proc_timeout
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the scenarios did not finish", cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic load_table();
    // rst, n, id0, id1, len, gap (0 is random), stall, bdly, bwait, bid, fault
    rows[0] = '{1'b0, 2'd1, 4'h3, 4'h0, 8'd2, 8'd0, 8'd0, 8'd3, 8'd8, 4'h3, 1'b0};
    rows[1] = '{1'b0, 2'd2, 4'h1, 4'h5, 8'd1, 8'd1, 8'd0, 8'd2, 8'd8, 4'h1, 1'b0};
    rows[2] = '{1'b0, 2'd2, 4'h6, 4'h6, 8'd0, 8'd0, 8'd0, 8'd4, 8'd8, 4'h6, 1'b0};
    rows[3] = '{1'b0, 2'd1, 4'h2, 4'h0, 8'd1, 8'd0, 8'd0, 8'd2, 8'd8, 4'h9, 1'b1};
    rows[4] = '{1'b0, 2'd1, 4'h4, 4'h0, 8'd1, 8'd0, 8'd0, 8'd2, 8'd8, 4'h4, 1'b1};
    rows[5] = '{1'b1, 2'd1, 4'h7, 4'h0, 8'd0, 8'd0, 8'd0, 8'd9, 8'd5, 4'h7, 1'b1};
    rows[6] = '{1'b1, 2'd1, 4'h7, 4'h0, 8'd3, 8'd0, 8'd0, 8'd5, 8'd5, 4'h7, 1'b0};
    rows[7] = '{1'b0, 2'd1, 4'ha, 4'h0, 8'd1, 8'd6, 8'd0, 8'd2, 8'd8, 4'ha, 1'b1};
    rows[8] = '{1'b1, 2'd1, 4'hc, 4'h0, 8'd2, 8'd0, 8'd6, 8'd2, 8'd8, 4'hc, 1'b1};
    rows[9] = '{1'b1, 2'd2, 4'h8, 4'hd, 8'd2, 8'd0, 8'd1, 8'd3, 8'd9, 4'h8, 1'b0};
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got == exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      row_errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    exp_irq   = 1'b0;
    exp_cause = FAULT_NONE;
    exp_id    = '0;
  endtask

  // Cycle of every handshake, counted from the first cycle of the scenario
  task automatic plan_row();
    int g;
    g = (cur.gap == 0) ? 1 + int'(lcg_next() % 2) : int'(cur.gap);
    aw_ids[0] = cur.id0;
    aw_ids[1] = cur.id1;
    b_ids[0]  = cur.bid;
    b_ids[1]  = cur.id1;
    for (int k = 0; k < int'(cur.n); k++) begin
      a_cyc[k] = k;
      f_cyc[k] = (k == 0) ? int'(cur.n) - 1 + g : l_cyc[k-1] + 1;
      l_cyc[k] = (cur.len == 0) ? f_cyc[k] : f_cyc[k] + int'(cur.len) + int'(cur.stall);
      // The first write is still queued for W when the second AW arrives
      w1[k] = 2 + ((k == 1) ? int'(cur.len) + 1 : 0);
    end
    for (int k = 0; k < int'(cur.n); k++) begin
      b_cyc[k] = l_cyc[int'(cur.n) - 1] + int'(cur.bdly) + k;
    end
    last_cyc = b_cyc[int'(cur.n) - 1] + 2;
  endtask

  // A phase that starts at cycle s with budget d faults at s + d + 2 unless it ends first
  task automatic predict_fault(output fault_e cause_p, output id_t id_p);
    int best;
    int c;
    best    = 1 << 30;
    cause_p = FAULT_NONE;
    id_p    = '0;
    for (int k = 0; k < int'(cur.n); k++) begin
      c = a_cyc[k] + w1[k] + 2;
      if ((c <= f_cyc[k]) && (c < best)) begin
        best    = c;
        cause_p = FAULT_AW_W;
        id_p    = aw_ids[k];
      end
      c = f_cyc[k] + int'(cur.len) + 5;
      if ((cur.len != 0) && (c <= l_cyc[k]) && (c < best)) begin
        best    = c;
        cause_p = FAULT_W_DATA;
        id_p    = aw_ids[k];
      end
      c = l_cyc[k] + int'(cur.bwait) + 2;
      if (((b_ids[k] != aw_ids[k]) || (c <= b_cyc[k])) && (c < best)) begin
        best    = c;
        cause_p = FAULT_B_WAIT;
        id_p    = aw_ids[k];
      end
    end
    for (int k = 0; k < int'(cur.n); k++) begin
      if ((b_ids[k] != aw_ids[k]) && (b_cyc[k] < best)) begin
        best    = b_cyc[k];
        cause_p = FAULT_UNWANTED_B;
        id_p    = b_ids[k];
      end
    end
  endtask

  task automatic drive_cycle(input int c);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    w_last   = 1'b0;
    b_valid  = 1'b0;
    for (int k = 0; k < int'(cur.n); k++) begin
      if (c == a_cyc[k]) begin
        aw_valid = 1'b1;
        aw_id    = aw_ids[k];
        aw_len   = cur.len;
      end
      if (((c >= f_cyc[k]) && (c < f_cyc[k] + int'(cur.len))) || (c == l_cyc[k])) begin
        w_valid = 1'b1;
        w_last  = (c == l_cyc[k]);
      end
      if (c == b_cyc[k]) begin
        b_valid = 1'b1;
        b_id    = b_ids[k];
      end
    end
  endtask

  // Latency outputs settle one cycle after the handshake that ends the phase
  task automatic check_latencies(input int e);
    for (int k = 0; k < int'(cur.n); k++) begin
      if (e == f_cyc[k]) begin
        compare_value("lat_aw_w_o", 32'(lat_aw_w), 32'(f_cyc[k] - a_cyc[k]));
      end
      if (e == l_cyc[k]) begin
        compare_value("lat_w_data_o", 32'(lat_w_data), 32'(l_cyc[k] - f_cyc[k]));
      end
      if (e == b_cyc[k]) begin
        compare_value("lat_b_wait_o", 32'(lat_b_wait), 32'(b_cyc[k] - l_cyc[k]));
      end
    end
  endtask

  task automatic run_row(input int idx);
    fault_e cause_p;
    id_t    id_p;
    logic   lat_on;
    row_errors    = 0;
    budget_b_wait = cur.bwait;
    plan_row();
    predict_fault(cause_p, id_p);
    // Only the first fault since reset is latched
    lat_on = !exp_irq && (cause_p == FAULT_NONE);
    if (!exp_irq && (cause_p != FAULT_NONE)) begin
      exp_irq   = 1'b1;
      exp_cause = cause_p;
      exp_id    = id_p;
    end
    if (cur.fault != exp_irq) begin
      $display("Test %0d: the table and the budget model disagree on the fault", idx);
      row_errors++;
    end
    for (int c = 0; c <= last_cyc; c++) begin
      @(posedge clk);
      #2;
      if (lat_on) begin
        check_latencies(c - 1);
      end
      drive_cycle(c);
    end
    compare_value("irq_o", 32'(irq), 32'(exp_irq));
    compare_value("cause_o", 32'(cause), 32'(exp_cause));
    compare_value("fault_id_o", 32'(fault_id), 32'(exp_id));
    if (row_errors == 0) begin
      $display("Test %0d passed", idx);
    end else begin
      $display("Test %0d failed with %0d errors", idx, row_errors);
      tests_failed++;
    end
  endtask

  initial begin : proc_main
    reset         = 1'b1;
    aw_valid      = 1'b0;
    aw_ready      = 1'b1;
    aw_id         = '0;
    aw_len        = '0;
    w_valid       = 1'b0;
    w_ready       = 1'b1;
    w_last        = 1'b0;
    b_valid       = 1'b0;
    b_ready       = 1'b1;
    b_id          = '0;
    budget_b_wait = 8'd8;
    lcg_state     = 32'h3d9;
    tests_failed  = 0;
    load_table();
    apply_reset();
    for (int i = 0; i < NumRows; i++) begin
      cur = rows[i];
      if (cur.rst) begin
        apply_reset();
      end
      run_row(i);
    end
    $display("Summary: %0d tests, %0d passed, %0d failed", NumRows, NumRows - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: wr_guard_top.f
hdl/wr_guard_pkg.sv
hdl/wr_mon_if.sv
hdl/txn_lookup.sv
hdl/txn_counters.sv
hdl/wr_txn_manager.sv
hdl/wr_guard_top.sv
dv/wr_guard_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the write guard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module wr_guard_tb -f wr_guard_top.f -o wr_guard_sim

out=$(./obj_dir/wr_guard_sim)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1
